// File: flow_stim.txt
// columns: I_FFFFFFFF_EE_XXXXXXXX, one row per cycle after reset
// I = {fetch_ready, branch_cond, hreadyd, irq}, F = fetch_inst
// E = {3'b0, stall, new_pc, data_access, irq_ack, issued_valid}, X = issued_inst
// reset released, RESET cycle
A_00000013_10_00000000
// plain stream
A_00100293_00_00000000
A_00200313_01_00100293
A_00300393_01_00200313
// jal taken, fetch not ready for three cycles
A_010000EF_19_00300393
2_00000013_18_00300393
2_00000013_18_00300393
2_00000013_18_00300393
A_00100293_08_00300393
A_00100293_00_00300393
// beq with branch_cond
E_00000463_19_00100293
A_00200313_08_00100293
// bne without branch_cond flows through
A_00209463_00_00100293
A_00200313_01_00209463
// load with wait states, store right after hreadyd
A_0000A103_05_00200313
8_0020A023_11_0000A103
8_0020A023_10_0000A103
A_0020A023_04_0000A103
8_00300393_11_0020A023
A_00300393_00_0020A023
A_00100293_01_00300393
// interrupt entry sequence
B_00200313_01_00100293
B_00300393_13_00200313
A_00300393_00_00200313
A_00300393_01_00000093
A_00300393_01_00000113
A_00300393_19_00000193
A_00300393_08_00000193
// handler body, second irq masked, mret inside handler
B_00100293_00_00000193
B_30200073_01_00100293
// exit sequence
A_00300393_11_30200073
A_00300393_00_30200073
A_00300393_01_00000213
A_00300393_19_00000293
A_00300393_08_00000293
// mret outside a handler is a plain instruction
A_30200073_00_00000293
A_00200313_01_30200073
A_00000013_01_00200313

// File: tb.f
+incdir+.
flow_pkg.sv
dec_if.sv
inst_decode.sv
urom.sv
flow_ctrl.sv
issue_stage.sv
flow_top.sv
tb_flow.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the flow controller testbench with verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module tb_flow -o tb_flow
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

sim_out=$(./obj_dir/tb_flow)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if echo "$sim_out" | grep -qF '*** PASSED ***'; then
   exit 0
fi
exit 1

// File: tb_flow.sv
module tb_flow
   import flow_pkg::*;
();

   // unused stim entries stay all ones
   localparam int MAX_ROWS     = 256;
   localparam int RESET_CYCLES = 16;
   localparam int CLK_PERIOD   = 10;

   logic  clk;
   logic  rst_n;
   inst_t fetch_inst;
   logic  fetch_ready;
   logic  branch_cond;
   logic  hreadyd;
   logic  irq;
   logic  stall;
   logic  new_pc;
   logic  data_access;
   logic  irq_ack;
   inst_t issued_inst;
   logic  issued_valid;

   // row holds {fetch_ready, branch_cond, hreadyd, irq} then fetch_inst and expectations
   logic [75:0] stim_mem [0:MAX_ROWS-1];
   int          n_rows;
   // issued_inst is only known after the first issue
   logic        inst_loaded;

   flow_top flow_top_i (
      .clk          (clk),
      .rst_n        (rst_n),
      .fetch_inst   (fetch_inst),
      .fetch_ready  (fetch_ready),
      .branch_cond  (branch_cond),
      .hreadyd      (hreadyd),
      .irq          (irq),
      .stall        (stall),
      .new_pc       (new_pc),
      .data_access  (data_access),
      .irq_ack      (irq_ack),
      .issued_inst  (issued_inst),
      .issued_valid (issued_valid)
   );

   always #5 clk = ~clk;

   task automatic check_val(input logic [31:0] actual, input logic [31:0] expected,
                            input string name);
      if (actual !== expected) begin
         $display("** Error at time %0t: %s is %h, expected %h",
                  $time, name, actual, expected);
         $display("*** FAILED ***");
         $fatal(1, "mismatch on %s", name);
      end
   endtask

   // flag bits 4 down to 0 are stall, new_pc, data_access, irq_ack and issued_valid
   task automatic compare_outputs(input logic [7:0] exp_flags, input inst_t exp_inst);
      check_val(32'(stall), 32'(exp_flags[4]), "stall");
      check_val(32'(new_pc), 32'(exp_flags[3]), "new_pc");
      check_val(32'(data_access), 32'(exp_flags[2]), "data_access");
      check_val(32'(irq_ack), 32'(exp_flags[1]), "irq_ack");
      check_val(32'(issued_valid), 32'(exp_flags[0]), "issued_valid");
      if (exp_flags[0]) begin
         inst_loaded = 1'b1;
      end
      // held value is checked too once something was issued
      if (inst_loaded) begin
         check_val(issued_inst, exp_inst, "issued_inst");
      end
   endtask

   // controller parked in RESET with only stall up
   task automatic reset_phase();
      repeat (RESET_CYCLES) begin
         @(posedge clk);
         rst_n <= 1'b0;
         #(CLK_PERIOD - 1);
         compare_outputs(8'h10, INST_NOP);
      end
   endtask

   // one row per cycle with reset released on the first row
   task automatic play_rows();
      logic [75:0] row;
      for (int r = 0; r < n_rows; r++) begin
         row = stim_mem[r];
         @(posedge clk);
         rst_n       <= 1'b1;
         fetch_ready <= row[75];
         branch_cond <= row[74];
         hreadyd     <= row[73];
         irq         <= row[72];
         fetch_inst  <= row[71:40];
         // sample one unit before the next edge
         #(CLK_PERIOD - 1);
         compare_outputs(row[39:32], row[31:0]);
      end
   endtask

   initial begin
      clk         = 1'b0;
      rst_n       = 1'b0;
      fetch_inst  = INST_NOP;
      fetch_ready = 1'b1;
      branch_cond = 1'b0;
      hreadyd     = 1'b1;
      irq         = 1'b0;
      inst_loaded = 1'b0;
      n_rows      = 0;

      for (int i = 0; i < MAX_ROWS; i++) begin
         stim_mem[i] = '1;
      end
      $readmemh("flow_stim.txt", stim_mem);
      // first all-ones entry ends the table
      while (n_rows < MAX_ROWS && stim_mem[n_rows] != '1) begin
         n_rows++;
      end

      if (n_rows == 0) begin
         $display("flow_stim.txt is missing or holds no rows");
         $display("*** FAILED ***");
         $fatal(1, "no stimulus");
      end else begin
         reset_phase();
         play_rows();
         $display("*** PASSED ***");
         $finish;
      end
   end

   // watchdog sized from reset plus the row count
   initial begin
      #1;
      #((RESET_CYCLES + n_rows) * CLK_PERIOD + 100);
      $display("timeout: the run went past the expected number of cycles");
      $display("*** FAILED ***");
      $fatal(1, "watchdog expired");
   end

endmodule

// File: flow_top.sv
module flow_top
   import flow_pkg::*;
(
   input  logic  clk,
   input  logic  rst_n,
   input  inst_t fetch_inst,
   input  logic  fetch_ready,
   input  logic  branch_cond,
   input  logic  hreadyd,
   input  logic  irq,
   output logic  stall,
   output logic  new_pc,
   output logic  data_access,
   output logic  irq_ack,
   output inst_t issued_inst,
   output logic  issued_valid
);

   // decode flags, decode to controller
   dec_if dec_bus ();

   inst_t cur_inst;
   inst_t urom_inst;
   logic  in_handler;
   logic  accept;
   logic  bypass_next;

   inst_decode inst_decode_i (
      .cur_inst    (cur_inst),
      .branch_cond (branch_cond),
      .in_handler  (in_handler),
      .dec         (dec_bus.decode)
   );

   flow_ctrl flow_ctrl_i (
      .clk         (clk),
      .rst_n       (rst_n),
      .fetch_ready (fetch_ready),
      .hreadyd     (hreadyd),
      .irq         (irq),
      .dec         (dec_bus.ctrl),
      .stall       (stall),
      .new_pc      (new_pc),
      .data_access (data_access),
      .irq_ack     (irq_ack),
      .accept      (accept),
      .bypass_next (bypass_next),
      .in_handler  (in_handler),
      .urom_inst   (urom_inst)
   );

   // picks fetch or micro-rom word and registers the issue
   issue_stage issue_stage_i (
      .clk          (clk),
      .rst_n        (rst_n),
      .fetch_inst   (fetch_inst),
      .urom_inst    (urom_inst),
      .accept       (accept),
      .bypass_next  (bypass_next),
      .cur_inst     (cur_inst),
      .issued_inst  (issued_inst),
      .issued_valid (issued_valid)
   );

endmodule

// File: issue_stage.sv
module issue_stage
   import flow_pkg::*;
(
   input  logic  clk,
   input  logic  rst_n,
   input  inst_t fetch_inst,
   input  inst_t urom_inst,
   input  logic  accept,
   input  logic  bypass_next,
   // current instruction back to decode
   output inst_t cur_inst,
   output inst_t issued_inst,
   output logic  issued_valid
);

   // source select for this cycle
   logic bypass_r;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         bypass_r <= 1'b0;
      end else begin
         bypass_r <= bypass_next;
      end
   end

   // registered select keeps decode out of a loop
   assign cur_inst = bypass_r ? urom_inst : fetch_inst;

   // issued word holds between accepts
   always_ff @(posedge clk) begin
      if (accept) begin
         issued_inst <= cur_inst;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         issued_valid <= 1'b0;
      end else begin
         issued_valid <= accept;
      end
   end

endmodule

// File: flow_ctrl.sv
`include "flow_settings.svh"

module flow_ctrl
   import flow_pkg::*;
(
   input  logic   clk,
   input  logic   rst_n,
   // fetch has the new-pc target
   input  logic   fetch_ready,
   // data bus ready level
   input  logic   hreadyd,
   input  logic   irq,
   dec_if.ctrl    dec,
   output logic   stall,
   output logic   new_pc,
   output logic   data_access,
   output logic   irq_ack,
   // current instruction taken this cycle
   output logic   accept,
   // next instruction comes from the micro-rom
   output logic   bypass_next,
   output logic   in_handler,
   output inst_t  urom_inst
);

   localparam urom_addr_t ENTRY = urom_addr_t'(`FLOW_IRQ_ENTRY_ADDR);
   localparam urom_addr_t EXIT  = urom_addr_t'(`FLOW_IRQ_EXIT_ADDR);
   localparam urom_addr_t LAST  = urom_addr_t'(`FLOW_UROM_DEPTH - 1);

   pstate_e    state_r;
   pstate_e    state_nxt;
   urom_addr_t urom_addr_r;
   urom_addr_t urom_start;
   logic       urom_load;
   logic       urom_inc;
   logic       handler_set;
   logic       handler_clr;
   logic       do_dispatch;

   always_comb begin
      stall       = 1'b0;
      new_pc      = 1'b0;
      data_access = 1'b0;
      irq_ack     = 1'b0;
      bypass_next = 1'b0;
      urom_load   = 1'b0;
      urom_inc    = 1'b0;
      urom_start  = ENTRY;
      handler_set = 1'b0;
      handler_clr = 1'b0;
      do_dispatch = 1'b0;
      state_nxt   = CONT;

      unique case (state_r)
         RESET: begin
            stall = 1'b1;
         end
         CONT: begin
            do_dispatch = 1'b1;
         end
         BRANCH: begin
            new_pc = 1'b1;
            // hold until fetch has the target
            if (!fetch_ready) begin
               stall     = 1'b1;
               state_nxt = BRANCH;
            end
         end
         WAITLD: begin
            if (!hreadyd) begin
               stall     = 1'b1;
               state_nxt = WAITLD;
            end else begin
               do_dispatch = 1'b1;
            end
         end
         IRQ_BEGIN: begin
            irq_ack     = 1'b1;
            stall       = 1'b1;
            handler_set = 1'b1;
            urom_load   = 1'b1;
            urom_start  = ENTRY;
            bypass_next = 1'b1;
            state_nxt   = IRQ_CONT;
         end
         RETI_BEGIN: begin
            stall       = 1'b1;
            handler_clr = 1'b1;
            urom_load   = 1'b1;
            urom_start  = EXIT;
            bypass_next = 1'b1;
            state_nxt   = RETI_CONT;
         end
         IRQ_CONT, RETI_CONT: begin
            bypass_next = 1'b1;
            // closing jump, keep the word up through BRANCH
            if (dec.branch_taken) begin
               new_pc    = 1'b1;
               stall     = 1'b1;
               state_nxt = BRANCH;
            end else begin
               urom_inc  = 1'b1;
               state_nxt = state_r;
            end
         end
      endcase

      // normal dispatch, in priority order
      if (do_dispatch) begin
         if (dec.branch_taken) begin
            new_pc    = 1'b1;
            stall     = 1'b1;
            state_nxt = BRANCH;
         end else if (dec.mem_read || dec.mem_write) begin
            data_access = 1'b1;
            state_nxt   = WAITLD;
         end else if (irq && !in_handler) begin
            // masked inside the handler
            state_nxt = IRQ_BEGIN;
         end else if (dec.reti) begin
            state_nxt = RETI_BEGIN;
         end
      end
   end

   // branch and the sequence starts never take the current word
   assign accept = !stall && (state_r != RESET) && (state_r != IRQ_BEGIN) &&
                   (state_r != RETI_BEGIN) && (state_r != BRANCH);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state_r <= RESET;
      end else begin
         state_r <= state_nxt;
      end
   end

   // micro-rom address counter
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         urom_addr_r <= '0;
      end else if (urom_load) begin
         urom_addr_r <= urom_start;
      end else if (urom_inc) begin
         urom_addr_r <= urom_addr_r + urom_addr_t'(1);
      end
   end

   // handler flag, set on entry and dropped at return
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         in_handler <= 1'b0;
      end else if (handler_set) begin
         in_handler <= 1'b1;
      end else if (handler_clr) begin
         in_handler <= 1'b0;
      end
   end

   urom urom_i (
      .addr (urom_addr_r),
      .dout (urom_inst)
   );

   // one ack per interrupt
   assert property (@(posedge clk) disable iff (!rst_n)
      irq_ack |=> !irq_ack)
      else $error("irq_ack held longer than one cycle");

   // every sequence must reach its jump before the top of the rom
   assert property (@(posedge clk) disable iff (!rst_n)
      urom_inc |-> (urom_addr_r != LAST))
      else $error("micro-rom address ran past the last word");

endmodule

// File: urom.sv
`include "flow_settings.svh"

module urom
   import flow_pkg::*;
(
   input  urom_addr_t addr,
   output inst_t      dout
);

   // sequence start words
   localparam urom_addr_t ENTRY = urom_addr_t'(`FLOW_IRQ_ENTRY_ADDR);
   localparam urom_addr_t EXIT  = urom_addr_t'(`FLOW_IRQ_EXIT_ADDR);

   // addi xN, x0, 0 for N = 1..5
   localparam inst_t ADDI_X1 = 32'h0000_0093;
   localparam inst_t ADDI_X2 = 32'h0000_0113;
   localparam inst_t ADDI_X3 = 32'h0000_0193;
   localparam inst_t ADDI_X4 = 32'h0000_0213;
   localparam inst_t ADDI_X5 = 32'h0000_0293;

   // jal x0, 0 closes each sequence
   localparam inst_t JAL_X0 = 32'h0000_006F;

   always_comb begin
      case (addr)
         // entry sequence
         ENTRY:                      dout = ADDI_X1;
         ENTRY + urom_addr_t'(1):    dout = ADDI_X2;
         ENTRY + urom_addr_t'(2):    dout = ADDI_X3;
         ENTRY + urom_addr_t'(3):    dout = JAL_X0;
         // exit sequence
         EXIT:                       dout = ADDI_X4;
         EXIT + urom_addr_t'(1):     dout = ADDI_X5;
         EXIT + urom_addr_t'(2):     dout = JAL_X0;
         // unused words
         default:                    dout = INST_NOP;
      endcase
   end

endmodule

// File: inst_decode.sv
module inst_decode
   import flow_pkg::*;
(
   // current instruction from fetch or micro-rom
   input  inst_t  cur_inst,
   // from the external comparator
   input  logic   branch_cond,
   // handler flag from the controller
   input  logic   in_handler,
   dec_if.decode  dec
);

   opcode_t opcode;
   logic    is_jump;
   logic    is_cond_branch;
   logic    is_mret;

   assign opcode = cur_inst[6:0];

   // jal and jalr always redirect
   assign is_jump = (opcode == OPC_JAL) || (opcode == OPC_JALR);

   // conditional branch taken only with the comparator result
   assign is_cond_branch = (opcode == OPC_BRANCH);

   // exact word match only
   assign is_mret = (cur_inst == INST_MRET);

   always_comb begin
      dec.branch_taken = is_jump || (is_cond_branch && branch_cond);
      dec.mem_read     = (opcode == OPC_LOAD);
      dec.mem_write    = (opcode == OPC_STORE);
      // mret outside a handler falls through as a plain instruction
      dec.reti         = is_mret && in_handler;
   end

endmodule

// File: dec_if.sv
// decode flags for the current instruction
interface dec_if;

   // jal, jalr, or conditional branch with its condition met
   logic branch_taken;
   // load opcode
   logic mem_read;
   // store opcode
   logic mem_write;
   // mret seen while inside the handler
   logic reti;

   // decode side drives all flags
   modport decode (
      output branch_taken,
      output mem_read,
      output mem_write,
      output reti
   );

   // controller only looks
   modport ctrl (
      input branch_taken,
      input mem_read,
      input mem_write,
      input reti
   );

endinterface

// File: flow_pkg.sv
`include "flow_settings.svh"

package flow_pkg;

   // one instruction word
   typedef logic [`FLOW_INST_W-1:0] inst_t;

   // word address into the micro-rom
   typedef logic [$clog2(`FLOW_UROM_DEPTH)-1:0] urom_addr_t;

   // major opcode field, bits 6:0
   typedef logic [6:0] opcode_t;

   // pipeline controller states
   typedef enum logic [2:0] {
      RESET      = 3'd0,
      CONT       = 3'd1,
      BRANCH     = 3'd2,
      WAITLD     = 3'd3,
      IRQ_BEGIN  = 3'd4,
      IRQ_CONT   = 3'd5,
      RETI_BEGIN = 3'd6,
      RETI_CONT  = 3'd7
   } pstate_e;

   // rv32i opcodes the controller cares about
   localparam opcode_t OPC_JAL    = 7'b1101111;
   localparam opcode_t OPC_JALR   = 7'b1100111;
   localparam opcode_t OPC_BRANCH = 7'b1100011;
   localparam opcode_t OPC_LOAD   = 7'b0000011;
   localparam opcode_t OPC_STORE  = 7'b0100011;

   // full words
   localparam inst_t INST_MRET = 32'h3020_0073;
   localparam inst_t INST_NOP  = 32'h0000_0013;

endpackage

// File: flow_settings.svh
`ifndef FLOW_SETTINGS_SVH
`define FLOW_SETTINGS_SVH

// width of one instruction word
`define FLOW_INST_W 32

// number of micro-rom words, sets the address width too
`define FLOW_UROM_DEPTH 16

// first word of the interrupt entry sequence
`define FLOW_IRQ_ENTRY_ADDR 0

// first word of the interrupt exit sequence
// keep it clear of the entry block
`define FLOW_IRQ_EXIT_ADDR 8

`endif
